// ==== Makefile ====
# Verilator build and run of the clock demo testbench
VERILATOR ?= verilator
TOP       ?= clk_demo_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass message shows up on a line of its own
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/channel_counter.sv ====
// channel counter that counts its ticks and keeps a periodic pulse level
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module channel_counter #(
    parameter int PERIOD = 4 // pulse period in ticks, 1 or more
) (
    input  logic                 CLKOUT4,
    input  logic                 rst,
    input  logic                 tick,
    output clk_demo_pkg::count_t count,
    output logic                 pulse
);
    import clk_demo_pkg::*;

    localparam int PH_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    // phase tracks count modulo PERIOD
    // avoids a 32 bit divider just to test divisibility
    logic [PH_W-1:0] phase;
    logic            phase_wrap; // phase at PERIOD-1
    logic            divisible; // current count is a multiple of PERIOD

    assign phase_wrap = (int'(phase) == PERIOD - 1);
    assign divisible = (phase == '0);

    // tick count, moves one cycle after the strobe
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            count <= '0;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    // phase follows count through the same ticks
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            phase <= '0;
        end else if (tick) begin
            if (phase_wrap) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // pulse sampled from the old count on every tick
    // so it holds for one whole tick interval
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            pulse <= 1'b0;
        end else if (tick) begin
            pulse <= divisible;
        end
    end

    // with PERIOD of 1 phase sits at zero and pulse rises on the first tick

endmodule

// ==== logic/clk_demo_defs.svh ====
// clock demo constants for channel ratios, pulse periods and display sizing
`ifndef CLK_DEMO_DEFS_SVH
`define CLK_DEMO_DEFS_SVH

// channel count, one per divided output rate
`define NUM_CH 6

// tick divide ratios in CLKOUT4 cycles
`define DIV_0 5
`define DIV_1 5
`define DIV_2 30
`define DIV_3 2
`define DIV_4 20
`define DIV_5 1

// prescaler width, enough for the largest ratio
`define PRE_W 5

// channels whose pulses get tallied
`define PULSE_A_CH 2
`define PULSE_B_CH 3

// pulse period in ticks per channel
`define PULSE_PERIOD(ch) (((ch) == `PULSE_B_CH) ? 100 : 4)

`define CNT_W 32 // channel count width
`define SW_W 16 // switches and leds

// seven segment display
`define DIGITS 8
`define SCAN_DIV 8 // cycles per lit digit
`define SEG_W 7

`endif

// ==== logic/clk_demo_pkg.sv ====
// clock demo shared types and the hex to seven segment encoder
`include "clk_demo_defs.svh"

package clk_demo_pkg;

    typedef logic [`CNT_W-1:0] count_t; // channel tick count
    typedef logic [`NUM_CH-1:0] tick_vec_t; // one strobe per channel
    typedef logic [3:0] sel_t; // display select from switches
    typedef logic [$clog2(`DIGITS)-1:0] digit_t;
    typedef logic [`SEG_W-1:0] seg_t; // bit 0 is segment a, active low

    // nibble to active low segment pattern
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t lit; // active high pattern, g down to a
        case (nibble)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c; // lower case b
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e; // lower case d
            4'he: lit = 7'h79;
            default: lit = 7'h71; // F
        endcase
        return ~lit;
    endfunction

endpackage

// ==== logic/clk_demo_top.sv ====
// clock demo top level tying ticks, channel counters and the display chain together
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module clk_demo_top (
    input  logic                CLKOUT4,
    input  logic                rst,
    input  logic [`SW_W-1:0]    sw,
    output logic [`SW_W-1:0]    led,
    output logic [`DIGITS-1:0]  an,
    output clk_demo_pkg::seg_t  segment
);
    import clk_demo_pkg::*;

    tick_vec_t         tick; // per channel enables
    count_t            counts [`NUM_CH];
    logic [`NUM_CH-1:0] pulse; // pulse level per channel
    count_t            shown_value; // value under display

    // divided rate strobes
    tick_generator tick_generator_inst (
        .CLKOUT4 (CLKOUT4),
        .rst     (rst),
        .tick    (tick)
    );

    // one counter per divided rate
    generate
        for (genvar ch = 0; ch < `NUM_CH; ch++) begin : g_channel
            channel_counter #(
                .PERIOD (`PULSE_PERIOD(ch))
            ) channel_counter_inst (
                .CLKOUT4 (CLKOUT4),
                .rst     (rst),
                .tick    (tick[ch]),
                .count   (counts[ch]),
                .pulse   (pulse[ch])
            );
        end
    endgenerate

    // switches, tallies of two chosen pulses, value select
    display_select display_select_inst (
        .CLKOUT4     (CLKOUT4),
        .rst         (rst),
        .sw          (sw),
        .counts      (counts),
        .pulse_a     (pulse[`PULSE_A_CH]), // every 4 ticks
        .pulse_b     (pulse[`PULSE_B_CH]), // every 100 ticks
        .led         (led),
        .shown_value (shown_value)
    );

    // scanned display
    seven_segment seven_segment_inst (
        .CLKOUT4     (CLKOUT4),
        .rst         (rst),
        .shown_value (shown_value),
        .an          (an),
        .segment     (segment)
    );

    // count change shows on segment two cycles after the count register
    // switch change reaches shown_value three cycles later

endmodule

// ==== logic/display_select.sv ====
// display select with switch sync, led mirror, pulse tallies and the value mux
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module display_select (
    input  logic                 CLKOUT4,
    input  logic                 rst,
    input  logic [`SW_W-1:0]     sw,
    input  clk_demo_pkg::count_t counts [`NUM_CH],
    input  logic                 pulse_a,
    input  logic                 pulse_b,
    output logic [`SW_W-1:0]     led,
    output clk_demo_pkg::count_t shown_value
);
    import clk_demo_pkg::*;

    // selects past the channel counts pick the tallies
    localparam sel_t SEL_TALLY_A = sel_t'(`NUM_CH);
    localparam sel_t SEL_TALLY_B = sel_t'(`NUM_CH + 1);

    logic [`SW_W-1:0] sw_d; // first switch flop
    logic [1:0]       pulse_in; // a in bit 0, b in bit 1
    logic [2:0]       sync [2]; // bit 0 first flop, bit 2 edge reference
    count_t           tally [2];
    sel_t             sel;
    count_t           sel_value;

    assign pulse_in = {pulse_b, pulse_a};
    assign sel = led[$bits(sel_t)-1:0]; // synchronized switches drive the select

    // two flop switch synchronizer, second stage is the led output
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            sw_d <= '0;
            led <= '0;
        end else begin
            sw_d <= sw;
            led <= sw_d;
        end
    end

    // synchronizer plus edge detect per pulse
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            for (int k = 0; k < 2; k++) begin
                sync[k] <= '0;
                tally[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                sync[k] <= {sync[k][1:0], pulse_in[k]}; // shift in
                if (sync[k][1] && !sync[k][2]) begin
                    tally[k] <= tally[k] + 1'b1; // rising edge seen
                end
            end
        end
    end

    // value mux
    always_comb begin
        sel_value = '0; // unused selects show zero
        for (int c = 0; c < `NUM_CH; c++) begin
            if (sel == sel_t'(c)) begin
                sel_value = counts[c];
            end
        end
        if (sel == SEL_TALLY_A) begin
            sel_value = tally[0];
        end
        if (sel == SEL_TALLY_B) begin
            sel_value = tally[1];
        end
    end

    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            shown_value <= '0;
        end else begin
            shown_value <= sel_value; // one cycle behind counts and tallies
        end
    end

endmodule

// ==== logic/seven_segment.sv ====
// seven segment driver that scans eight digits and encodes the shown value
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module seven_segment (
    input  logic                 CLKOUT4,
    input  logic                 rst,
    input  clk_demo_pkg::count_t shown_value,
    output logic [`DIGITS-1:0]   an,
    output clk_demo_pkg::seg_t   segment
);
    import clk_demo_pkg::*;

    localparam int SCAN_W = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;
    localparam int NIB_W = `CNT_W / `DIGITS; // bits per digit, 4

    logic [SCAN_W-1:0]  scan_cnt; // cycles on the current digit
    logic               scan_wrap;
    digit_t             digit; // lit digit index
    logic [NIB_W-1:0]   nibble;
    logic [`DIGITS-1:0] digit_hot; // active high one hot of digit

    assign scan_wrap = (int'(scan_cnt) == `SCAN_DIV - 1);
    assign nibble = shown_value[int'(digit) * NIB_W +: NIB_W];
    assign digit_hot = {{(`DIGITS - 1){1'b0}}, 1'b1} << digit;

    // scan prescaler
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (scan_wrap) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit index steps once per scan period
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            digit <= '0;
        end else if (scan_wrap) begin
            if (digit == digit_t'(`DIGITS - 1)) begin
                digit <= '0; // back to the rightmost digit
            end else begin
                digit <= digit + 1'b1;
            end
        end
    end

    // registered anodes and segments
    // both lag the digit index and the shown value by one cycle
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            an <= '1; // all digits dark
            segment <= '1; // all segments off
        end else begin
            an <= ~digit_hot; // active low anode
            segment <= hex_to_seg(nibble);
        end
    end

    // digit k always carries nibble k
    // so the value reads left to right as most to least significant

endmodule

// ==== logic/tick_generator.sv ====
// tick generator with one prescaler per channel, each raising a single cycle strobe
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module tick_generator (
    input  logic                    CLKOUT4,
    input  logic                    rst,
    output clk_demo_pkg::tick_vec_t tick
);
    import clk_demo_pkg::*;

    // divide ratio per channel, stands in for the divided output clocks
    localparam int DIV_RATIO [`NUM_CH] = '{
        `DIV_0,
        `DIV_1,
        `DIV_2,
        `DIV_3,
        `DIV_4,
        `DIV_5
    };

    logic [`PRE_W-1:0] pre [`NUM_CH]; // prescaler counts

    // each prescaler wraps at its ratio
    // tick goes high for the cycle after the wrap edge
    always_ff @(posedge CLKOUT4) begin
        if (rst) begin
            for (int i = 0; i < `NUM_CH; i++) begin
                pre[i] <= '0;
            end
            tick <= '0; // no strobes while in reset
        end else begin
            for (int i = 0; i < `NUM_CH; i++) begin
                if (int'(pre[i]) == DIV_RATIO[i] - 1) begin
                    pre[i] <= '0; // wrap
                    tick[i] <= 1'b1;
                end else begin
                    pre[i] <= pre[i] + 1'b1;
                    tick[i] <= 1'b0;
                end
            end
        end
    end

    // ratio of 1 never leaves zero, so that tick stays high every cycle
    // first strobe lands DIV cycles after reset drops

endmodule

// ==== tb.f ====
+incdir+logic
logic/clk_demo_pkg.sv
logic/tick_generator.sv
logic/channel_counter.sv
logic/display_select.sv
logic/seven_segment.sv
logic/clk_demo_top.sv
verif/clk_demo_props.sv
verif/clk_demo_tb.sv

// ==== verif/clk_demo_props.sv ====
// clock demo assertions on the led mirror and the scanned anodes
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module clk_demo_props (
    input logic               CLKOUT4,
    input logic               rst,
    input logic [`SW_W-1:0]   sw,
    input logic [`SW_W-1:0]   led,
    input logic [`DIGITS-1:0] an
);

    // never two digits lit at once
    one_anode_low: assert property (
        @(posedge CLKOUT4) disable iff (rst) $countones(~an) <= 1
    ) else $error("more than one anode low, an %b", an);

    // two flop path from switches to leds, once both flops left reset
    led_follows_sw: assert property (
        @(posedge CLKOUT4) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2)) |-> (led == $past(sw, 2))
    ) else $error("led %h differs from sw two cycles earlier", led);

    // reset darkens the display
    dark_in_reset: assert property (
        @(posedge CLKOUT4) rst |=> (an == '1)
    ) else $error("anode low right after a reset cycle, an %b", an);

endmodule

bind clk_demo_top clk_demo_props clk_demo_props_inst (
    .CLKOUT4 (CLKOUT4),
    .rst     (rst),
    .sw      (sw),
    .led     (led),
    .an      (an)
);

// ==== verif/clk_demo_tb.sv ====
// clock demo testbench with random switches, a cycle model and output checks
`timescale 1ns/100ps
`include "clk_demo_defs.svh"

module clk_demo_tb;

    localparam int RUN_CYCLES = 20000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4; // quarter run of margin
    localparam int DIV [`NUM_CH] = '{`DIV_0, `DIV_1, `DIV_2, `DIV_3, `DIV_4, `DIV_5};
    // lit segments g down to a, hex digits 0 to f
    localparam logic [6:0] SEG_ON [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic               CLKOUT4;
    logic               rst;
    logic [`SW_W-1:0]   sw;
    logic [`SW_W-1:0]   led;
    logic [`DIGITS-1:0] an;
    logic [`SEG_W-1:0]  segment;

    // cycle model state
    int                 m_pre [`NUM_CH]; // prescalers
    logic [`NUM_CH-1:0] m_tick;
    logic [31:0]        m_count [`NUM_CH];
    logic [`NUM_CH-1:0] m_pulse;
    logic [`SW_W-1:0]   m_sw_d;
    logic [`SW_W-1:0]   m_led;
    logic [2:0]         m_sync [2]; // two sync flops plus edge reference
    logic [31:0]        m_tally [2];
    int                 m_sel;
    logic [31:0]        m_shown;
    int                 m_scan;
    int                 m_digit;
    logic [`DIGITS-1:0] m_an;
    logic [`SEG_W-1:0]  m_seg;

    int         errors = 0;
    int         checks = 0;
    int         hold; // cycles left on the current select
    logic [3:0] sel;
    int         timeout_cycles;

    clk_demo_top clk_demo_top_inst (
        .CLKOUT4 (CLKOUT4),
        .rst     (rst),
        .sw      (sw),
        .led     (led),
        .an      (an),
        .segment (segment)
    );

    initial begin
        CLKOUT4 = 1'b0;
        forever #20 CLKOUT4 = ~CLKOUT4; // 40 ns period
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // model steps downstream first so every stage sees last cycle's values
    always @(posedge CLKOUT4) begin
        if (rst) begin
            for (int i = 0; i < `NUM_CH; i++) begin
                m_pre[i] = 0;
                m_count[i] = '0;
            end
            for (int k = 0; k < 2; k++) begin
                m_sync[k] = '0;
                m_tally[k] = '0;
            end
            m_tick = '0;
            m_pulse = '0;
            m_sw_d = '0;
            m_led = '0;
            m_shown = '0;
            m_scan = 0;
            m_digit = 0;
            m_an = '1; // display dark
            m_seg = '1;
        end else begin
            m_an = ~(`DIGITS'(1) << m_digit); // lit digit from the old index
            m_seg = ~SEG_ON[m_shown[m_digit*4 +: 4]];
            if (m_scan == `SCAN_DIV - 1) begin
                m_scan = 0;
                m_digit = (m_digit + 1) % `DIGITS;
            end else begin
                m_scan++;
            end
            m_sel = int'(m_led[3:0]); // synced switches pick the value
            if (m_sel < `NUM_CH) begin
                m_shown = m_count[m_sel];
            end else if (m_sel == `NUM_CH) begin
                m_shown = m_tally[0];
            end else if (m_sel == `NUM_CH + 1) begin
                m_shown = m_tally[1];
            end else begin
                m_shown = '0;
            end
            for (int k = 0; k < 2; k++) begin
                if (m_sync[k][1] && !m_sync[k][2]) begin
                    m_tally[k] = m_tally[k] + 1; // rising edge
                end
                m_sync[k] = {m_sync[k][1:0], m_pulse[(k == 0) ? `PULSE_A_CH : `PULSE_B_CH]};
            end
            m_led = m_sw_d;
            m_sw_d = sw;
            for (int c = 0; c < `NUM_CH; c++) begin
                if (m_tick[c]) begin
                    m_pulse[c] = (m_count[c] % `PULSE_PERIOD(c)) == 0; // old count
                    m_count[c] = m_count[c] + 1;
                end
            end
            for (int i = 0; i < `NUM_CH; i++) begin
                if (m_pre[i] == DIV[i] - 1) begin
                    m_pre[i] = 0;
                    m_tick[i] = 1'b1;
                end else begin
                    m_pre[i]++;
                    m_tick[i] = 1'b0;
                end
            end
        end
    end

    // compare mid cycle where all outputs have settled
    always @(negedge CLKOUT4) begin
        check_value("led mirror", 32'(m_led), 32'(led));
        check_value("anode scan", 32'(m_an), 32'(an));
        check_value($sformatf("segment select %0d", m_sel), 32'(m_seg), 32'(segment));
    end

    initial begin
        void'($urandom(15));
        rst = 1'b1;
        sw = '0;
        sel = 4'd0;
        hold = 0;
        repeat (5) @(posedge CLKOUT4);
        rst <= 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge CLKOUT4);
            if (hold == 0) begin
                sel = 4'($urandom_range(15, 0)); // new display select
                hold = $urandom_range(2000, 200);
            end
            hold--;
            sw <= {12'($urandom), sel}; // upper switches change every cycle
            if (cyc == RUN_CYCLES / 2) begin
                rst <= 1'b1; // mid run reset
            end
            if (cyc == RUN_CYCLES / 2 + 3) begin
                rst <= 1'b0;
            end
        end
        @(negedge CLKOUT4); // last compare
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        timeout_cycles = 0;
        while (timeout_cycles < TIMEOUT_CYCLES) begin
            @(posedge CLKOUT4);
            timeout_cycles++;
        end
        $display("timeout, the run was still going after %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
